/* Makefile */
# Verilator build and run of the dual-clock FIFO testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= asyncFifoTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "no pass report in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/asyncFifo.sv */
// Dual-clock FIFO top level, 8-bit words from iSrcClk to iDstClk.
// Write side offers wrEn and wrData and watches the early full flag.
// Read side raises rdEn while empty is low and takes rdData whenever
// rdValid pulses, two iDstClk cycles after the accepting edge.
// rstN is a single async reset, synchronized into each domain here.

module asyncFifo
    import fifoPkg::*;
(
    input  logic      iSrcClk,
    input  logic      iDstClk,
    input  logic      rstN,
    input  logic      wrEn,
    input  logic      rdEn,
    input  fifoWord_t wrData,
    output logic      full,         // source domain
    output logic      empty,        // destination domain
    output logic      rdValid,      // destination domain
    output fifoWord_t rdData        // destination domain
);

    logic     srcRstN, dstRstN;     // per-domain resets
    logic     ramWe, ramRe;         // ram strobes
    fifoPtr_t wrPtr, rdPtr;         // local binary pointers
    fifoPtr_t wrPtrSync, rdPtrSync; // pointers after crossing

    //------------------------------
    // reset and pointer crossing
    //------------------------------
    resetSync srcRstSync_i (.iClk(iSrcClk), .rstN(rstN), .syncRstN(srcRstN));
    resetSync dstRstSync_i (.iClk(iDstClk), .rstN(rstN), .syncRstN(dstRstN));

    // write pointer into the read domain
    graySync wrPtrSync_i (.iClk(iDstClk), .syncRstN(dstRstN), .ptrIn(wrPtr), .ptrOut(wrPtrSync));
    // read pointer into the write domain
    graySync rdPtrSync_i (.iClk(iSrcClk), .syncRstN(srcRstN), .ptrIn(rdPtr), .ptrOut(rdPtrSync));

    //------------------------------
    // control and storage
    //------------------------------
    fifoWriteCtrl writeCtrl_i (
        .iSrcClk(iSrcClk),      .srcRstN(srcRstN),
        .wrEn(wrEn),            .rdPtrSync(rdPtrSync),
        .wrPtr(wrPtr),          .ramWe(ramWe),          .full(full)
    );

    fifoReadCtrl readCtrl_i (
        .iDstClk(iDstClk),      .dstRstN(dstRstN),
        .rdEn(rdEn),            .wrPtrSync(wrPtrSync),
        .rdPtr(rdPtr),          .ramRe(ramRe),
        .rdValid(rdValid),      .empty(empty)
    );

    // ram output register drives rdData straight, aligned with rdValid
    dualPortRam ram_i (
        .iSrcClk(iSrcClk),      .we(ramWe),
        .wrAddr(wrPtr[addrWidth-1:0]),                  .wrData(wrData),
        .iDstClk(iDstClk),      .re(ramRe),
        .rdAddr(rdPtr[addrWidth-1:0]),                  .rdData(rdData)
    );

endmodule

/* rtl/dualPortRam.sv */
// Simple dual-port storage for the FIFO.
// Write port on the source clock, registered read port on the destination
// clock. rdData only changes on a read strobe and holds between reads.

module dualPortRam
    import fifoPkg::*;
(
    // write side
    input  logic                 iSrcClk,
    input  logic                 we,        // store wrData at wrAddr
    input  logic [addrWidth-1:0] wrAddr,
    input  fifoWord_t            wrData,
    // read side
    input  logic                 iDstClk,
    input  logic                 re,        // load rdData from rdAddr
    input  logic [addrWidth-1:0] rdAddr,
    output fifoWord_t            rdData
);

    fifoWord_t mem [fifoDepth];             // fifoDepth words

    //------------------------------
    // write port, source domain
    //------------------------------
    always_ff @(posedge iSrcClk)
    begin
        if (we)
            mem[wrAddr] <= wrData;
    end

    //------------------------------
    // read port, destination domain
    //------------------------------
    // word lands here one edge after the read strobe
    always_ff @(posedge iDstClk)
    begin
        if (re)
            rdData <= mem[rdAddr];
    end

endmodule

/* rtl/fifoPkg.sv */
// Shared sizes and types for the dual-clock FIFO.
// Every FIFO module pulls these in with a wildcard import in its header.
// Depth must stay a power of two so the extra pointer bit marks a wrap.

package fifoPkg;

    //------------------------------
    // word and storage sizes
    //------------------------------
    localparam int dataWidth  = 8;                      // payload bits per word
    localparam int fifoDepth  = 16;                     // words held in the ram
    localparam int addrWidth  = $clog2(fifoDepth);      // ram address bits
    localparam int ptrWidth   = addrWidth + 1;          // address plus wrap bit

    // free words still left when full goes high
    localparam int fullMargin = 3;

    //------------------------------
    // types
    //------------------------------
    typedef logic [dataWidth-1:0] fifoWord_t;           // one data word
    typedef logic [ptrWidth-1:0]  fifoPtr_t;            // read or write pointer

    // occupancy at which full rises, 13 for the default sizes
    localparam fifoPtr_t fullLevel = fifoPtr_t'(fifoDepth - fullMargin);

endpackage

/* rtl/fifoReadCtrl.sv */
// Read-side control of the dual-clock FIFO.
// Accepts a read whenever rdEn is high and empty is low, one per cycle,
// and delivers rdValid two destination cycles after the accepting edge.
// headPtr moves on acceptance and sets empty. rdPtr moves when the word
// has actually left the ram, so it addresses the ram and is the pointer
// handed back to the write side.

module fifoReadCtrl
    import fifoPkg::*;
(
    input  logic     iDstClk,
    input  logic     dstRstN,       // destination domain reset
    input  logic     rdEn,          // read request level
    input  fifoPtr_t wrPtrSync,     // write pointer seen from this domain
    output fifoPtr_t rdPtr,         // ram read pointer
    output logic     ramRe,         // ram read strobe, valid pipe stage 1
    output logic     rdValid,       // word on rdData, valid pipe stage 2
    output logic     empty          // nothing left to accept
);

    fifoPtr_t headPtr;              // next word to accept
    fifoPtr_t headNext;             // head after this edge
    logic     rdAccept;             // read taken at this edge

    assign rdAccept = rdEn && !empty;                   // ignore reads while empty
    assign headNext = headPtr + ptrWidth'(rdAccept);

    //------------------------------
    // accept side
    //------------------------------
    always_ff @(posedge iDstClk or negedge dstRstN)
    begin
        if (!dstRstN)
        begin
            headPtr <= '0;
            empty   <= 1'b1;        // nothing written yet
        end
        else
        begin
            headPtr <= headNext;
            empty   <= (headNext == wrPtrSync);         // caught up with writer
        end
    end

    //------------------------------
    // valid pipe and ram pointer
    //------------------------------
    always_ff @(posedge iDstClk or negedge dstRstN)
    begin
        if (!dstRstN)
        begin
            ramRe   <= 1'b0;
            rdValid <= 1'b0;
            rdPtr   <= '0;
        end
        else
        begin
            ramRe   <= rdAccept;    // ram reads at the next edge
            rdValid <= ramRe;       // lines up with the ram output register
            if (ramRe)
                rdPtr <= rdPtr + 1'b1;                  // slot freed once read
        end
    end

endmodule

/* rtl/fifoWriteCtrl.sv */
// Write-side control of the dual-clock FIFO.
// Holds the binary write pointer, blocks writes while full, and raises an
// early full flag once only fullMargin free words are left. Occupancy is
// taken against the synchronized read pointer, which lags the true one,
// so the flag can only come early and never lets the ram overflow.

module fifoWriteCtrl
    import fifoPkg::*;
(
    input  logic     iSrcClk,
    input  logic     srcRstN,       // source domain reset
    input  logic     wrEn,          // write request level
    input  fifoPtr_t rdPtrSync,     // read pointer seen from this domain
    output fifoPtr_t wrPtr,         // binary write pointer
    output logic     ramWe,         // accepted write
    output logic     full           // early full flag
);

    fifoPtr_t wrPtrNext;            // pointer after this edge
    fifoPtr_t occupancy;            // words held after this edge

    //------------------------------
    // accept and advance
    //------------------------------
    assign ramWe     = wrEn && !full;                       // drop while full
    assign wrPtrNext = wrPtr + ptrWidth'(ramWe);

    // wrap bit makes the difference come out right across a wrap
    assign occupancy = wrPtrNext - rdPtrSync;

    //------------------------------
    // pointer and flag registers
    //------------------------------
    always_ff @(posedge iSrcClk or negedge srcRstN)
    begin
        if (!srcRstN)
        begin
            wrPtr <= '0;
            full  <= 1'b0;
        end
        else
        begin
            wrPtr <= wrPtrNext;
            // 13th word in rises full, so the next request is dropped
            full  <= (occupancy >= fullLevel);
        end
    end

endmodule

/* rtl/graySync.sv */
// Pointer crossing between the two FIFO clock domains.
// Binary pointer in from the sending side, encoded to Gray, pulled through
// two flops of the receiving clock, then decoded and registered as binary.
// ptrIn has to be a flop output of the sending clock so that the Gray
// value moves by one bit per step.

module graySync
    import fifoPkg::*;
(
    input  logic     iClk,          // receiving clock
    input  logic     syncRstN,      // receiving domain reset
    input  fifoPtr_t ptrIn,         // binary, sending domain
    output fifoPtr_t ptrOut         // binary, receiving domain
);

    fifoPtr_t grayIn;               // encoded pointer, still sending domain
    fifoPtr_t grayMeta;             // first sample flop
    fifoPtr_t grayStable;           // second sample flop
    fifoPtr_t binDecoded;           // Gray back to binary

    // binary to Gray
    assign grayIn = ptrIn ^ (ptrIn >> 1);

    //------------------------------
    // Gray to binary, msb down
    //------------------------------
    always_comb
    begin
        binDecoded[ptrWidth-1] = grayStable[ptrWidth-1];   // msb passes straight
        for (int i = ptrWidth - 2; i >= 0; i--)
            binDecoded[i] = binDecoded[i+1] ^ grayStable[i];
    end

    //------------------------------
    // two-flop synchronizer plus output register
    //------------------------------
    always_ff @(posedge iClk or negedge syncRstN)
    begin
        if (!syncRstN)
        begin
            grayMeta   <= '0;
            grayStable <= '0;
            ptrOut     <= '0;
        end
        else
        begin
            grayMeta   <= grayIn;           // async capture
            grayStable <= grayMeta;
            ptrOut     <= binDecoded;       // keeps the decode xor chain off the far path
        end
    end

endmodule

/* rtl/resetSync.sv */
// Reset synchronizer for one clock domain.
// Assertion is immediate and asynchronous, release is taken through two
// flops of the local clock. Instantiate once per domain.

module resetSync
(
    input  logic iClk,          // domain clock
    input  logic rstN,          // raw async reset, active low
    output logic syncRstN       // clean reset for this domain
);

    logic releaseMeta;          // first flop, may go metastable on release

    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            releaseMeta <= 1'b0;
            syncRstN    <= 1'b0;
        end
        else
        begin
            releaseMeta <= 1'b1;            // shift a one in
            syncRstN    <= releaseMeta;     // second flop settles it
        end
    end

endmodule

/* sim.f */
rtl/fifoPkg.sv
rtl/resetSync.sv
rtl/graySync.sv
rtl/dualPortRam.sv
rtl/fifoWriteCtrl.sv
rtl/fifoReadCtrl.sv
rtl/asyncFifo.sv
sim/clockGen.sv
sim/asyncFifo_properties.sv
sim/asyncFifoTb.sv

/* sim/asyncFifoTb.sv */
// Testbench for the dual-clock FIFO.
// Applies a table of write and read bursts to asyncFifo, keeps a reference
// queue of accepted words and checks data order, read latency, the early
// full level and reads on an empty FIFO. Ends with one summary line.

module asyncFifoTb
    import fifoPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    //------------------------------
    // stimulus table
    //------------------------------
    typedef struct packed {
        int wrCount;                    // writes presented
        int wrDuty;                     // wrEn every n-th source cycle
        int rdCount;                    // reads presented
        int rdDuty;                     // rdEn every n-th destination cycle
        bit overlap;                    // both sides at once, else writes first
    } stimRow_t;

    localparam int numRows = 7;
    localparam stimRow_t stimTable [numRows] = '{
        '{0,  1, 8,  1, 1'b0},          // reads on an empty fifo
        '{1,  1, 1,  1, 1'b0},          // single word
        '{20, 1, 20, 1, 1'b0},          // fill past the early full level
        '{40, 1, 40, 2, 1'b1},          // fast writer, slow reader, wraps
        '{40, 3, 40, 1, 1'b1},          // slow writer, fast reader
        '{24, 1, 24, 1, 1'b1},          // back to back reads
        '{30, 2, 30, 1, 1'b0}           // slow fill then read out
    };
    localparam logic [31:0] rngSeed = 32'h2690_f5e9;
    localparam int settleCycles = 8;    // source cycles for rdPtr to cross back

    logic        iSrcClk, iDstClk;
    logic        rstN, wrEn, rdEn;
    fifoWord_t   wrData;
    logic        full, empty, rdValid;
    fifoWord_t   rdData;

    fifoWord_t   refQueue [$];          // accepted words, oldest first
    fifoWord_t   expectedWord;
    logic [31:0] rngState;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;        // destination cycles since start
    int          rowWrAccepted = 0;
    int          rowRdValid = 0;
    int          assertFails;
    logic        acceptAge1 = 1'b0;     // read accepted one edge ago
    logic        acceptAge2 = 1'b0;     // two edges ago
    logic        monitorOn = 1'b0;
    logic        fullCheckOn = 1'b0;    // only while writing alone from empty

    clockGen #(.periodNs(70))  srcClkGen_i (.clk(iSrcClk));
    clockGen #(.periodNs(100)) dstClkGen_i (.clk(iDstClk));

    asyncFifo asyncFifo_i (
        .iSrcClk(iSrcClk),  .iDstClk(iDstClk),  .rstN(rstN),
        .wrEn(wrEn),        .rdEn(rdEn),        .wrData(wrData),
        .full(full),        .empty(empty),      .rdValid(rdValid),
        .rdData(rdData)
    );

    //------------------------------
    // helpers
    //------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic fifoWord_t nextWord();
        rngState = xorshift32(rngState);
        return rngState[dataWidth-1:0];
    endfunction

    // table length plus fixed slack for reset, drains and gaps
    function automatic int timeoutLimit();
        int total;
        total = 200;
        for (int r = 0; r < numRows; r++)
            total += stimTable[r].wrCount * stimTable[r].wrDuty
                   + stimTable[r].rdCount * stimTable[r].rdDuty;
        return total;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic writeBurst(input int count, input int duty);
        for (int n = 0; n < count; n++)
        begin
            for (int c = 1; c < duty; c++)
            begin
                @(posedge iSrcClk);
                wrEn <= 1'b0;               // idle slot
            end
            @(posedge iSrcClk);
            wrEn   <= 1'b1;
            wrData <= nextWord();
        end
        @(posedge iSrcClk);
        wrEn <= 1'b0;
        @(negedge iSrcClk);                 // last sample taken by now
    endtask

    task automatic readBurst(input int count, input int duty);
        for (int n = 0; n < count; n++)
        begin
            for (int c = 1; c < duty; c++)
            begin
                @(posedge iDstClk);
                rdEn <= 1'b0;
            end
            @(posedge iDstClk);
            rdEn <= 1'b1;
        end
        @(posedge iDstClk);
        rdEn <= 1'b0;
        @(negedge iDstClk);
    endtask

    // reads until every accepted word has come out
    task automatic drainFifo();
        while (refQueue.size() != 0)
        begin
            @(posedge iDstClk);
            rdEn <= 1'b1;
            @(negedge iDstClk);
        end
        @(posedge iDstClk);
        rdEn <= 1'b0;
    endtask

    task automatic runRow(input int idx);
        stimRow_t row;
        int       waited;
        int       expectAccepted;
        row = stimTable[idx];
        rowWrAccepted = 0;
        rowRdValid = 0;
        if (row.overlap)
        begin
            fork
                writeBurst(row.wrCount, row.wrDuty);
                readBurst(row.rdCount, row.rdDuty);
            join
        end
        else
        begin
            fullCheckOn = 1'b1;
            writeBurst(row.wrCount, row.wrDuty);
            fullCheckOn = 1'b0;
            waited = 0;
            while (rowWrAccepted > 0 && empty && waited < 5)
            begin
                @(negedge iDstClk);
                waited++;
            end
            if (rowWrAccepted > 0 && empty)
            begin
                errorCount++;
                $display("Row %0d: empty still high %0d cycles after the write", idx, waited);
            end
            readBurst(row.rdCount, row.rdDuty);
            // no reads during the fill, so writes stop at the full level
            expectAccepted = (row.wrCount < int'(fullLevel)) ? row.wrCount : int'(fullLevel);
            checkValue("accepted writes", expectAccepted, rowWrAccepted);
        end
        drainFifo();
        repeat (settleCycles) @(posedge iSrcClk);
        @(negedge iSrcClk);
        checkValue("rdValid count", rowWrAccepted, rowRdValid);
        checkValue("queue size", 0, refQueue.size());
    endtask

    //------------------------------
    // monitors
    //------------------------------
    always @(posedge iSrcClk)
    begin
        if (fullCheckOn)                    // full follows occupancy one edge late
            checkValue("full", 32'(rowWrAccepted >= int'(fullLevel)), 32'(full));
        if (wrEn && !full)
        begin
            refQueue.push_back(wrData);
            rowWrAccepted++;
        end
    end

    always @(posedge iDstClk)
    begin
        if (monitorOn)
        begin
            checkValue("rdValid", 32'(acceptAge2), 32'(rdValid));
            if (rdValid === 1'b1)
            begin
                rowRdValid++;
                if (refQueue.size() == 0)
                begin
                    errorCount++;
                    $display("rdValid pulsed at %0t with no word left to deliver", $time);
                end
                else
                begin
                    expectedWord = refQueue.pop_front();
                    checkValue("rdData", 32'(expectedWord), 32'(rdData));
                end
            end
            acceptAge2 = acceptAge1;
            acceptAge1 = rdEn && !empty;    // accepted at this edge
        end
    end

    always @(posedge iDstClk)
    begin
        cycleCount++;
        if (cycleCount >= timeoutLimit())
        begin
            $display("Run timed out after %0d destination cycles", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //------------------------------
    // main sequence
    //------------------------------
    initial
    begin
        rstN = 1'b0;
        wrEn = 1'b0;
        rdEn = 1'b0;
        wrData = '0;
        rngState = rngSeed;
        repeat (5) @(posedge iDstClk);
        rstN <= 1'b1;
        repeat (3) @(posedge iDstClk);
        @(negedge iDstClk);
        checkValue("empty", 1, 32'(empty));
        checkValue("full", 0, 32'(full));
        checkValue("rdValid", 0, 32'(rdValid));
        monitorOn = 1'b1;
        for (int r = 0; r < numRows; r++)
            runRow(r);
        assertFails = asyncFifo_i.props_i.assertFails;
        $display("Errors: %0d, assertion failures: %0d, checks: %0d",
                 errorCount, assertFails, checkCount);
        if (errorCount == 0 && assertFails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sim/asyncFifo_properties.sv */
// Concurrent checks on the destination-side ports of the dual-clock FIFO.
// Bound into every asyncFifo instance. Failures raise $error and bump
// assertFails, which the testbench reads back at the end of the run.

module asyncFifo_properties
    import fifoPkg::*;
(
    input logic      iDstClk,
    input logic      rstN,
    input logic      rdEn,
    input logic      empty,
    input logic      full,
    input logic      rdValid,
    input fifoWord_t rdData
);

    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;                // failed assertion count

    // no accepted read, so no word two edges on
    noPhantomValid: assert property (@(posedge iDstClk) disable iff (!rstN)
        (!rdEn || empty) |-> ##2 !rdValid)
    else
    begin
        $error("rdValid without an accepted read two cycles before");
        assertFails++;
    end

    // flags still at reset values right after release
    resetFlags: assert property (@(posedge iDstClk) $rose(rstN) |-> (empty && !full))
    else
    begin
        $error("full or empty not at reset value after reset release");
        assertFails++;
    end

    dataKnown: assert property (@(posedge iDstClk) disable iff (!rstN)
        rdValid |-> !$isunknown(rdData))
    else
    begin
        $error("rdData unknown while rdValid is high");
        assertFails++;
    end

endmodule

bind asyncFifo asyncFifo_properties props_i (
    .iDstClk(iDstClk),  .rstN(rstN),        .rdEn(rdEn),
    .empty(empty),      .full(full),        .rdValid(rdValid),
    .rdData(rdData)
);

/* sim/clockGen.sv */
// Free-running clock for the testbench.
// One instance per clock domain, the period comes in as a parameter in ns.

module clockGen
#(
    parameter int periodNs = 100        // full period in ns
)
(
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
        clk = 1'b0;

    always #(periodNs / 2) clk = ~clk;  // half period high, half low

endmodule
